// File: Bender.yml
package:
  name: apb_timer_unit

sources:
  - verilog/timer_pkg.sv
  - verilog/timer_ctrl_if.sv
  - verilog/timer_counter.sv
  - verilog/timer_refclk_sync.sv
  - verilog/timer_channel.sv
  - verilog/timer_apb_regs.sv
  - verilog/apb_timer_unit.sv
  - target: simulation
    files:
      - verification/tb_apb_timer_unit.sv

// File: sim.f
verilog/timer_pkg.sv
verilog/timer_ctrl_if.sv
verilog/timer_counter.sv
verilog/timer_refclk_sync.sv
verilog/timer_channel.sv
verilog/timer_apb_regs.sv
verilog/apb_timer_unit.sv
verification/tb_apb_timer_unit.sv

// File: verification/tb_apb_timer_unit.sv
`timescale 1ns/10ps

module tb_apb_timer_unit;

	localparam int TIMEOUT = 1000;	// Cycle limit of every wait loop

	logic                             HCLK;
	logic                             HRESETn;
	logic [timer_pkg::APB_ADDR_W-1:0] paddr;
	timer_pkg::word_t                 pwdata;
	logic                             pwrite;
	logic                             psel;
	logic                             penable;
	timer_pkg::word_t                 prdata;
	logic                             pready;
	logic                             pslverr;
	logic                             ref_clk;
	logic                             event_lo;
	logic                             event_hi;
	logic                             irq_lo;
	logic                             irq_hi;
	logic                             busy;

	int               errors;
	int               timeouts;
	int               cyc;		// Free running HCLK cycle count
	int               mark;		// Cycle of the last write or irq
	int               ref_half;	// Reference half period in cycles, 0 stops it
	int               ref_cnt;
	int               fd;
	int               n;
	int unsigned      seed;
	logic [31:0]      op;
	timer_pkg::word_t off;
	timer_pkg::word_t data;
	timer_pkg::word_t exp_val;
	timer_pkg::word_t rdata;
	logic [8*160-1:0] skip;

	apb_timer_unit i_apb_timer_unit (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.PADDR     (paddr),
		.PWDATA    (pwdata),
		.PWRITE    (pwrite),
		.PSEL      (psel),
		.PENABLE   (penable),
		.PRDATA    (prdata),
		.PREADY    (pready),
		.PSLVERR   (pslverr),
		.ref_clk_i (ref_clk),
		.event_lo_i(event_lo),
		.event_hi_i(event_hi),
		.irq_lo_o  (irq_lo),
		.irq_hi_o  (irq_hi),
		.busy_o    (busy)
	);

	always #4 HCLK = ~HCLK;

	always @(posedge HCLK) begin
		cyc <= cyc + 1;
		if (ref_half == 0) begin
			ref_cnt <= 0;
		end else if (ref_cnt == ref_half - 1) begin
			ref_cnt <= 0;
			ref_clk <= ~ref_clk;
		end else begin
			ref_cnt <= ref_cnt + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and bus tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_val(input string what, input timer_pkg::word_t actual,
		input timer_pkg::word_t expected, input timer_pkg::word_t tol);
		timer_pkg::word_t diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if (diff > tol) begin
			errors++;
			$display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h within %0d",
				$time, what, actual, expected, tol);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout: gave up waiting for %s after %0d cycles", what, TIMEOUT);
	endtask

	task automatic apb_access(input logic write, input timer_pkg::word_t addr,
		input timer_pkg::word_t wdata, output timer_pkg::word_t result);
		int cnt;
		cnt = 0;
		result = '0;
		repeat ($urandom_range(3, 0)) @(posedge HCLK);	// Random idle gap
		@(posedge HCLK);
		psel   <= 1'b1;
		pwrite <= write;
		paddr  <= addr[timer_pkg::APB_ADDR_W-1:0];
		pwdata <= wdata;
		@(negedge HCLK);
		check_val("PREADY in the setup phase", pready, 0, 0);
		@(posedge HCLK);
		penable <= 1'b1;
		@(negedge HCLK);
		while (!pready && cnt < TIMEOUT) begin
			@(negedge HCLK);
			cnt++;
		end
		if (pready) begin
			result = prdata;
			check_val("PSLVERR", pslverr, 0, 0);
		end else begin
			report_timeout("PREADY");
		end
		@(posedge HCLK);
		mark    = cyc;	// Writes take effect at this edge
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic pulse_event(input int ch);
		@(posedge HCLK);
		if (ch == 0) begin
			event_lo <= 1'b1;
		end else begin
			event_hi <= 1'b1;
		end
		@(posedge HCLK);
		event_lo <= 1'b0;
		event_hi <= 1'b0;
	endtask

	task automatic wait_irq(input int ch, input timer_pkg::word_t tol,
		input timer_pkg::word_t cycles);
		int cnt;
		cnt = 0;
		@(negedge HCLK);
		while (!(ch == 0 ? irq_lo : irq_hi) && cnt < TIMEOUT) begin
			@(negedge HCLK);
			cnt++;
		end
		if (ch == 0 ? irq_lo : irq_hi) begin
			check_val("irq delay in cycles", cyc - mark, cycles, tol);
			mark = cyc;	// Next irq is timed from this one
		end else begin
			report_timeout("an irq pulse");
		end
	endtask

	task automatic wait_ref_edges(input int count);
		int   cnt;
		int   seen;
		logic prev;
		cnt = 0;
		seen = 0;
		prev = ref_clk;
		while (seen < count && cnt < TIMEOUT) begin
			@(negedge HCLK);
			if (ref_clk && !prev) begin
				seen++;
			end
			prev = ref_clk;
			cnt++;
		end
		if (seen < count) begin
			report_timeout("reference clock edges");
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus file runner
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		errors = 0;
		timeouts = 0;
		cyc = 0;
		mark = 0;
		ref_half = 0;
		ref_cnt = 0;
		HCLK = 1'b0;
		HRESETn = 1'b0;
		paddr = '0;
		pwdata = '0;
		pwrite = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		ref_clk = 1'b0;
		event_lo = 1'b0;
		event_hi = 1'b0;
		seed = $urandom(6);
		repeat (2) @(posedge HCLK);
		HRESETn <= 1'b1;
		@(negedge HCLK);
		check_val("busy_o after reset", busy, 0, 0);
		check_val("irq_lo_o after reset", irq_lo, 0, 0);
		check_val("irq_hi_o after reset", irq_hi, 0, 0);
		fd = $fopen("verification/timer_stim.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file verification/timer_stim.txt");
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op == "#") begin
					n = $fgets(skip, fd);	// Comment line
				end else begin
					n = $fscanf(fd, "%h %h %h", off, data, exp_val);
					case (op)
						"W": apb_access(1'b1, off, data, rdata);
						"R": begin
							apb_access(1'b0, off, '0, rdata);
							check_val($sformatf("read of offset 0x%02h", off[7:0]),
								rdata, exp_val, data);
						end
						"E": pulse_event(off);
						"I": wait_irq(off, data, exp_val);
						"B": begin
							@(negedge HCLK);
							check_val("busy_o", busy, exp_val, 0);
						end
						"T": begin
							ref_half <= data;
							wait_ref_edges(exp_val);
						end
						default: begin
							errors++;
							$display("Unknown opcode in the stimulus file");
						end
					endcase
				end
			end
			$fclose(fd);
		end
		$display("Run complete with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verification/timer_stim.txt
# op off data exp, all fields hex; W writes data, R reads and allows data off exp, B checks busy
# E pulses the event of channel off, I waits for irq of channel off, exp cycles within data
# T sets the reference half period to data cycles and waits for exp rising edges
# Reset state
R 00 0 0
R 04 0 0
R 08 0 0
R 0c 0 0
R 10 0 0
R 14 0 0
R 28 0 0
B 00 0 0
# Read back, counter load and both counter resets
W 00 a5a5a500 0
R 00 0 a5a5a500
W 14 87654321 0
R 14 0 87654321
W 08 0000abcd 0
R 08 0 0000abcd
W 20 0 0
R 08 0 0
W 0c 00001234 0
R 0c 0 00001234
W 04 00000002 0
R 0c 0 0
R 04 0 0
# HCLK mode with compare 8 and reset on compare
W 20 0 0
W 00 14 0
W 10 8 0
W 18 0 0
I 00 0 9
I 00 0 9
R 08 4 4
R 08 4 4
W 00 0 0
B 00 0 0
# One shot with prescaler 3 and compare 5
W 24 0 0
W 14 5 0
W 04 364 0
W 1c 0 0
I 01 2 14
B 00 0 0
R 0c 0 5
R 04 0 364
# Reference clock mode over 4 periods
W 20 0 0
W 00 80 0
W 18 0 0
T 00 5 4
R 08 1 4
T 00 0 0
W 00 0 0
# Event start
W 04 0 0
E 01 0 0
B 00 0 0
W 04 8 0
B 00 0 0
E 01 0 0
B 00 0 1
R 04 0 9

// File: verilog/apb_timer_unit.sv
`timescale 1ns/10ps

module apb_timer_unit (
	input  logic                             HCLK,
	input  logic                             HRESETn,
	input  logic [timer_pkg::APB_ADDR_W-1:0] PADDR,
	input  timer_pkg::word_t                 PWDATA,
	input  logic                             PWRITE,
	input  logic                             PSEL,
	input  logic                             PENABLE,
	output timer_pkg::word_t                 PRDATA,
	output logic                             PREADY,
	output logic                             PSLVERR,
	input  logic                             ref_clk_i,
	input  logic                             event_lo_i,
	input  logic                             event_hi_i,
	output logic                             irq_lo_o,
	output logic                             irq_hi_o,
	output logic                             busy_o
);

	logic ref_edge;	// Shared by both channels

	timer_ctrl_if lo_if ();
	timer_ctrl_if hi_if ();

	assign PSLVERR = 1'b0;

	timer_apb_regs regs_u (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.paddr_i   (PADDR),
		.pwdata_i  (PWDATA),
		.pwrite_i  (PWRITE),
		.psel_i    (PSEL),
		.penable_i (PENABLE),
		.prdata_o  (PRDATA),
		.pready_o  (PREADY),
		.event_lo_i(event_lo_i),
		.event_hi_i(event_hi_i),
		.lo        (lo_if.regs),
		.hi        (hi_if.regs),
		.busy_o    (busy_o)
	);

	timer_refclk_sync sync_u (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.ref_clk_i (ref_clk_i),
		.ref_edge_o(ref_edge)
	);

	timer_channel chan_lo (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.ref_edge_i(ref_edge),
		.ctrl      (lo_if.chan),
		.irq_o     (irq_lo_o)
	);

	timer_channel chan_hi (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.ref_edge_i(ref_edge),
		.ctrl      (hi_if.chan),
		.irq_o     (irq_hi_o)
	);

endmodule

// File: verilog/timer_apb_regs.sv
`timescale 1ns/10ps

module timer_apb_regs (
	input  logic                              HCLK,
	input  logic                              HRESETn,
	input  logic [timer_pkg::APB_ADDR_W-1:0]  paddr_i,
	input  timer_pkg::word_t                  pwdata_i,
	input  logic                              pwrite_i,
	input  logic                              psel_i,
	input  logic                              penable_i,
	output timer_pkg::word_t                  prdata_o,
	output logic                              pready_o,
	input  logic                              event_lo_i,
	input  logic                              event_hi_i,
	timer_ctrl_if.regs                        lo,
	timer_ctrl_if.regs                        hi,
	output logic                              busy_o
);

	timer_pkg::reg_off_t off;
	logic                wr_en;
	logic                rd_en;

	// Next configuration word after writes, self-clear, starts and stops
	function automatic timer_pkg::word_t cfg_next(
		input timer_pkg::word_t cur,
		input logic             wr_cfg,
		input timer_pkg::word_t wdata,
		input logic             start,
		input logic             evt,
		input logic             stop
	);
		timer_pkg::word_t nxt;
		nxt = wr_cfg ? wdata : cur;
		if (cur[timer_pkg::CFG_RST]) begin
			nxt[timer_pkg::CFG_RST] = 1'b0;	// Lives for a single cycle
		end
		if (start || (evt && nxt[timer_pkg::CFG_EVT_EN])) begin
			nxt[timer_pkg::CFG_EN] = 1'b1;
		end else if (stop) begin
			nxt[timer_pkg::CFG_EN] = 1'b0;
		end
		return nxt;
	endfunction

	assign off      = paddr_i[$bits(timer_pkg::reg_off_t)-1:0];
	assign pready_o = psel_i & penable_i;	// Zero wait states
	assign wr_en    = pready_o & pwrite_i;
	assign rd_en    = pready_o & ~pwrite_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Command strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign lo.load     = wr_en && (off == timer_pkg::OFF_CNT_LO);
	assign hi.load     = wr_en && (off == timer_pkg::OFF_CNT_HI);
	assign lo.load_val = pwdata_i;
	assign hi.load_val = pwdata_i;
	assign lo.clear    = (wr_en && (off == timer_pkg::OFF_RST_LO)) | lo.cfg[timer_pkg::CFG_RST];
	assign hi.clear    = (wr_en && (off == timer_pkg::OFF_RST_HI)) | hi.cfg[timer_pkg::CFG_RST];

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			lo.cfg <= '0;
			hi.cfg <= '0;
			lo.cmp <= '0;
			hi.cmp <= '0;
		end else begin
			lo.cfg <= cfg_next(lo.cfg, wr_en && (off == timer_pkg::OFF_CFG_LO), pwdata_i,
				wr_en && (off == timer_pkg::OFF_START_LO), event_lo_i, lo.stop);
			hi.cfg <= cfg_next(hi.cfg, wr_en && (off == timer_pkg::OFF_CFG_HI), pwdata_i,
				wr_en && (off == timer_pkg::OFF_START_HI), event_hi_i, hi.stop);
			if (wr_en && (off == timer_pkg::OFF_CMP_LO)) begin
				lo.cmp <= pwdata_i;
			end
			if (wr_en && (off == timer_pkg::OFF_CMP_HI)) begin
				hi.cmp <= pwdata_i;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read mux
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		prdata_o = '0;
		if (rd_en) begin
			case (off)
				timer_pkg::OFF_CFG_LO: prdata_o = lo.cfg;
				timer_pkg::OFF_CFG_HI: prdata_o = hi.cfg;
				timer_pkg::OFF_CNT_LO: prdata_o = lo.value;
				timer_pkg::OFF_CNT_HI: prdata_o = hi.value;
				timer_pkg::OFF_CMP_LO: prdata_o = lo.cmp;
				timer_pkg::OFF_CMP_HI: prdata_o = hi.cmp;
				default:               prdata_o = '0;	// Commands and holes read zero
			endcase
		end
	end

	assign busy_o = lo.cfg[timer_pkg::CFG_EN] | hi.cfg[timer_pkg::CFG_EN];

	// Every access phase must follow a setup phase with the slave selected
	a_pready_sel: assert property (
		@(posedge HCLK) disable iff (!HRESETn)
		pready_o |-> psel_i && $past(psel_i)
	) else $error("timer_apb_regs: access phase without select");

endmodule

// File: verilog/timer_channel.sv
`timescale 1ns/10ps

module timer_channel (
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       ref_edge_i,
	timer_ctrl_if.chan ctrl,
	output logic       irq_o
);

	logic                cfg_en;
	logic                presc_en;
	logic                tick;
	logic                presc_tick;
	logic                presc_wrap;
	logic                presc_match;
	logic                presc_clear;
	logic                cnt_tick;
	logic                cnt_match;
	logic                cnt_clear;
	logic                cmp_hit_clr;
	logic                match;
	timer_pkg::presc_t   presc_cmp;

	assign cfg_en    = ctrl.cfg[timer_pkg::CFG_EN];
	assign presc_en  = ctrl.cfg[timer_pkg::CFG_PRESC_EN];
	assign presc_cmp = ctrl.cfg[timer_pkg::CFG_PRESC_LSB +: $bits(timer_pkg::presc_t)];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tick selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign tick        = cfg_en & (ctrl.cfg[timer_pkg::CFG_REF_SEL] ? ref_edge_i : 1'b1);
	assign presc_tick  = tick & presc_en;
	assign presc_wrap  = presc_tick & presc_match;	// Last tick of a prescaler period
	assign presc_clear = ctrl.clear | presc_wrap;

	timer_counter #(
		.WIDTH($bits(timer_pkg::presc_t))
	) presc_u (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.en_i      (presc_tick),
		.clear_i   (presc_clear),
		.load_i    (1'b0),
		.load_val_i('0),
		.cmp_i     (presc_cmp),
		.value_o   (),
		.match_o   (presc_match)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main counter and match
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign match       = cnt_match & cfg_en;
	assign ctrl.stop   = match & ctrl.cfg[timer_pkg::CFG_ONE_SHOT];
	assign cnt_tick    = (presc_en ? presc_wrap : tick) & ~ctrl.stop;	// One-shot holds the count
	assign cmp_hit_clr = match & ctrl.cfg[timer_pkg::CFG_CMP_CLR] & ~ctrl.load;	// Software load wins
	assign cnt_clear   = ctrl.clear | cmp_hit_clr;
	assign irq_o       = match & ctrl.cfg[timer_pkg::CFG_IRQ_EN];

	timer_counter #(
		.WIDTH($bits(timer_pkg::word_t))
	) count_u (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.en_i      (cnt_tick),
		.clear_i   (cnt_clear),
		.load_i    (ctrl.load),
		.load_val_i(ctrl.load_val),
		.cmp_i     (ctrl.cmp),
		.value_o   (ctrl.value),
		.match_o   (cnt_match)
	);

	// A one-shot match freezes the count for the register file to read
	a_stop_holds_count: assert property (
		@(posedge HCLK) disable iff (!HRESETn)
		ctrl.stop && !ctrl.cfg[timer_pkg::CFG_CMP_CLR] && !ctrl.clear && !ctrl.load
			|=> $stable(ctrl.value)
	) else $error("timer_channel: counter moved on one-shot stop");

endmodule

// File: verilog/timer_counter.sv
`timescale 1ns/10ps

module timer_counter #(
	parameter int WIDTH = 32
) (
	input  logic             HCLK,
	input  logic             HRESETn,
	input  logic             en_i,
	input  logic             clear_i,
	input  logic             load_i,
	input  logic [WIDTH-1:0] load_val_i,
	input  logic [WIDTH-1:0] cmp_i,
	output logic [WIDTH-1:0] value_o,
	output logic             match_o
);

	logic [WIDTH-1:0] count_q;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			count_q <= '0;
		end else if (clear_i) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= load_val_i;
		end else if (en_i) begin
			count_q <= count_q + 1'b1;	// Wraps silently at the top
		end
	end

	assign value_o = count_q;
	assign match_o = (count_q == cmp_i);

	// The channel must arbitrate compare-clear against software loads,
	// and APB pacing keeps CFG_RST clears apart from counter writes
	a_load_clear_excl: assert property (
		@(posedge HCLK) disable iff (!HRESETn)
		!(load_i && clear_i)
	) else $error("timer_counter: load and clear asserted together");

endmodule

// File: verilog/timer_ctrl_if.sv
`timescale 1ns/10ps

interface timer_ctrl_if;

	timer_pkg::word_t cfg;		// Registered configuration word
	timer_pkg::word_t cmp;		// Registered compare value
	logic             load;		// One-cycle counter write
	timer_pkg::word_t load_val;
	logic             clear;	// One-cycle counter and prescaler clear
	timer_pkg::word_t value;	// Current counter value
	logic             stop;		// One-shot request to drop the enable bit

	modport regs (
		output cfg,
		output cmp,
		output load,
		output load_val,
		output clear,
		input  value,
		input  stop
	);

	modport chan (
		input  cfg,
		input  cmp,
		input  load,
		input  load_val,
		input  clear,
		output value,
		output stop
	);

endinterface

// File: verilog/timer_pkg.sv
package timer_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] word_t;	// APB data, counter, compare and config words
	typedef logic [7:0]  presc_t;	// Prescaler compare value
	typedef logic [5:0]  reg_off_t;	// Register offset from the low address bits

	localparam int APB_ADDR_W = 12;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam reg_off_t OFF_CFG_LO   = 6'h00;
	localparam reg_off_t OFF_CFG_HI   = 6'h04;
	localparam reg_off_t OFF_CNT_LO   = 6'h08;	// Write loads, read returns the count
	localparam reg_off_t OFF_CNT_HI   = 6'h0C;
	localparam reg_off_t OFF_CMP_LO   = 6'h10;
	localparam reg_off_t OFF_CMP_HI   = 6'h14;
	localparam reg_off_t OFF_START_LO = 6'h18;	// Write only command
	localparam reg_off_t OFF_START_HI = 6'h1C;
	localparam reg_off_t OFF_RST_LO   = 6'h20;	// Write only command
	localparam reg_off_t OFF_RST_HI   = 6'h24;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Configuration word bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int CFG_EN        = 0;
	localparam int CFG_RST       = 1;	// Self-clearing
	localparam int CFG_IRQ_EN    = 2;
	localparam int CFG_EVT_EN    = 3;
	localparam int CFG_CMP_CLR   = 4;
	localparam int CFG_ONE_SHOT  = 5;
	localparam int CFG_PRESC_EN  = 6;
	localparam int CFG_REF_SEL   = 7;
	localparam int CFG_PRESC_LSB = 8;	// Prescaler value sits in bits 15:8

endpackage

// File: verilog/timer_refclk_sync.sv
`timescale 1ns/10ps

module timer_refclk_sync (
	input  logic HCLK,
	input  logic HRESETn,
	input  logic ref_clk_i,
	output logic ref_edge_o
);

	logic sync_q0;
	logic sync_q1;
	logic sync_q2;

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			sync_q0 <= 1'b0;
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
		end else begin
			sync_q0 <= ref_clk_i;	// First stage may go metastable
			sync_q1 <= sync_q0;
			sync_q2 <= sync_q1;	// Previous synchronized level
		end
	end

	// One HCLK pulse per rising reference edge
	assign ref_edge_o = sync_q1 & ~sync_q2;

endmodule
